// ==== src.f ====
source/decode_pkg.sv
source/instr_decoder.sv
source/imm_gen.sv
source/reg_file.sv
source/scoreboard.sv
source/decode_stage.sv
testbench/tb_clock.sv
testbench/decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
  import decode_pkg::*;

  localparam int WAIT_LIMIT = 50;  // cycles allowed for any single wait

  logic               clk, reset;
  logic               fe_valid, stall, wb_wr_reg, agex_mispred;
  instr_t             fe_inst;
  logic [DATA_W-1:0]  fe_pc, fe_pc_plus, fe_pc_next, wb_value;
  logic [REGNO_W-1:0] wb_regno, de_rd;
  logic               de_valid, de_is_br, de_is_jmp, de_rd_mem, de_wr_mem, de_wr_reg;
  logic [DATA_W-1:0]  de_pc, de_pc_plus, de_pc_next, de_rs1_val, de_rs2_val, de_imm;
  inst_op_t           de_op;
  logic [31:0]        rng_state = 32'd9243;

  tb_clock i_tb_clock (.clk(clk), .reset(reset));

  decode_stage i_decode_stage (.*);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state ^ (rng_state >> 15);  // fold the better upper bits down
  endfunction

  function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
    return {F7_BASE, rs2, rs1, F3_ADD, rd, OPC_OP};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected)
      stop_run($sformatf("FAIL at %0t: %s expected 0x%08h, got 0x%08h",
                         $time, name, expected, actual));
  endtask

  // call right after a rising edge
  task automatic drive_fetch(input logic [31:0] word, input logic [31:0] pc);
    fe_valid   <= 1'b1;
    fe_inst    <= word;
    fe_pc      <= pc;
    fe_pc_plus <= pc + 32'd4;
    fe_pc_next <= pc + 32'd4;
  endtask

  task automatic wb_write(input logic [4:0] regno, input logic [31:0] value);
    @(posedge clk);
    wb_wr_reg <= 1'b1;
    wb_regno  <= regno;
    wb_value  <= value;
    @(posedge clk);
    wb_wr_reg <= 1'b0;  // write lands at this edge
  endtask

  // returns at the falling edge after the instruction entered the latch
  task automatic issue(input logic [31:0] word, input logic [31:0] pc, output int stalls);
    int n;
    n = 0;
    @(posedge clk);
    drive_fetch(word, pc);
    @(negedge clk);
    while (stall) begin
      n++;
      if (n > WAIT_LIMIT) stop_run("timeout: decode never accepted the instruction");
      @(negedge clk);
    end
    @(posedge clk);
    fe_valid <= 1'b0;
    @(negedge clk);
    stalls = n;
  endtask

  // flags are {is_br, is_jmp, rd_mem, wr_mem, wr_reg}
  task automatic check_latch(input inst_op_t op, input logic [31:0] imm, input logic [4:0] flags,
                             input logic [4:0] rd, input logic [31:0] pc);
    check("de_valid", 32'd1, 32'(de_valid));
    check("de_op", 32'(op), 32'(de_op));
    check("de_imm", imm, de_imm);
    check("de_is_br", 32'(flags[4]), 32'(de_is_br));
    check("de_is_jmp", 32'(flags[3]), 32'(de_is_jmp));
    check("de_rd_mem", 32'(flags[2]), 32'(de_rd_mem));
    check("de_wr_mem", 32'(flags[1]), 32'(de_wr_mem));
    check("de_wr_reg", 32'(flags[0]), 32'(de_wr_reg));
    check("de_rd", 32'(rd), 32'(de_rd));
    check("de_pc", pc, de_pc);
    check("de_pc_plus", pc + 32'd4, de_pc_plus);
    check("de_pc_next", pc + 32'd4, de_pc_next);
  endtask

  task automatic run_case(input logic [31:0] word, input logic [31:0] pc, input inst_op_t op,
                          input logic [31:0] imm, input logic [4:0] flags, input logic [4:0] rd);
    int n;
    issue(word, pc, n);
    check_latch(op, imm, flags, rd, pc);
    if (flags[0]) wb_write(rd, next_rand());  // frees the busy bit again
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_idle();
    int n;
    check("stall", 32'd0, 32'(stall));
    check("de_valid", 32'd0, 32'(de_valid));
    check("de_wr_reg", 32'd0, 32'(de_wr_reg));
    check("de_rd_mem", 32'd0, 32'(de_rd_mem));
    check("de_wr_mem", 32'd0, 32'(de_wr_mem));
    check("de_is_br", 32'd0, 32'(de_is_br));
    check("de_is_jmp", 32'd0, 32'(de_is_jmp));
    for (int i = 0; i < REG_COUNT; i++) begin
      issue(add_word(5'd0, 5'(i), 5'(i)), 32'(i * 4), n);
      check("de_rs1_val", 32'd0, de_rs1_val);
      check("de_rs2_val", 32'd0, de_rs2_val);
    end
  endtask

  task automatic test_wb_read();
    logic [31:0] r, va, vb, vc;
    logic [4:0]  ra, rb;
    int          n;
    r  = next_rand();
    ra = 5'd1 + 5'(r[3:0] % 4'd15);  // 1..15
    rb = 5'd16 + 5'(r[7:4]);         // 16..31
    va = next_rand();
    vb = next_rand();
    vc = next_rand();
    wb_write(ra, va);
    wb_write(rb, vb);
    issue(add_word(5'd0, ra, rb), 32'h100, n);
    check("de_rs1_val", va, de_rs1_val);
    check("de_rs2_val", vb, de_rs2_val);
    wb_write(5'd0, next_rand());
    issue(add_word(5'd0, 5'd0, rb), 32'h104, n);
    check("de_rs1_val", 32'd0, de_rs1_val);
    // write and read of ra at the same edge
    @(posedge clk);
    wb_wr_reg <= 1'b1;
    wb_regno  <= ra;
    wb_value  <= vc;
    drive_fetch(add_word(5'd0, ra, 5'd0), 32'h108);
    @(negedge clk);
    check("stall", 32'd0, 32'(stall));
    @(posedge clk);
    wb_wr_reg <= 1'b0;
    fe_valid  <= 1'b0;
    @(negedge clk);
    check("de_valid", 32'd1, 32'(de_valid));
    check("de_rs1_val", vc, de_rs1_val);
  endtask

  task automatic test_decode();
    logic [31:0] r, pc;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] i12;
    logic [12:0] b13;
    logic [19:0] u20;
    logic [20:0] j21;
    for (int k = 0; k < 4; k++) begin
      r   = next_rand();
      rd  = r[4:0];
      rs1 = r[9:5];
      rs2 = r[14:10];
      i12 = r[26:15];
      r   = next_rand();
      b13 = {r[11:0], 1'b0};
      j21 = {r[31:12], 1'b0};
      u20 = r[19:0];
      pc  = next_rand() & 32'hffff_fffc;
      run_case({i12, rs1, F3_ADD, rd, OPC_OP_IMM}, pc, OP_ADDI,
               {{20{i12[11]}}, i12}, {4'b0000, rd != 5'd0}, rd);
      run_case({i12[11:5], rs2, rs1, F3_SW, i12[4:0], OPC_STORE}, pc, OP_SW,
               {{20{i12[11]}}, i12}, 5'b00010, i12[4:0]);
      run_case({b13[12], b13[10:5], rs2, rs1, F3_BEQ, b13[4:1], b13[11], OPC_BRANCH}, pc,
               OP_BEQ, {{19{b13[12]}}, b13}, 5'b10000, {b13[4:1], b13[11]});
      run_case({u20, rd, OPC_LUI}, pc, OP_LUI, {u20, 12'h000}, {4'b0000, rd != 5'd0}, rd);
      run_case({j21[20], j21[10:1], j21[11], j21[19:12], rd, OPC_JAL}, pc, OP_JAL,
               {{11{j21[20]}}, j21}, {4'b0100, rd != 5'd0}, rd);
      run_case({i12, rs1, F3_LW, rd, OPC_LOAD}, pc, OP_LW,
               {{20{i12[11]}}, i12}, {4'b0010, rd != 5'd0}, rd);
      run_case({i12, rs1, F3_JALR, rd, OPC_JALR}, pc, OP_JALR,
               {{20{i12[11]}}, i12}, {4'b0100, rd != 5'd0}, rd);
    end
  endtask

  task automatic test_raw_hazard();
    logic [31:0] v;
    int          n;
    v = next_rand();
    issue(add_word(5'd5, 5'd0, 5'd0), 32'h200, n);
    check("de_wr_reg", 32'd1, 32'(de_wr_reg));
    @(posedge clk);
    drive_fetch(add_word(5'd0, 5'd5, 5'd0), 32'h204);
    repeat (3) begin
      @(negedge clk);
      check("stall", 32'd1, 32'(stall));
      check("de_valid", 32'd0, 32'(de_valid));
    end
    @(posedge clk);
    wb_wr_reg <= 1'b1;
    wb_regno  <= 5'd5;
    wb_value  <= v;
    @(negedge clk);
    check("stall", 32'd1, 32'(stall));  // busy until the write edge
    @(posedge clk);
    wb_wr_reg <= 1'b0;
    @(negedge clk);
    check("stall", 32'd0, 32'(stall));
    check("de_valid", 32'd0, 32'(de_valid));
    @(posedge clk);
    fe_valid <= 1'b0;
    @(negedge clk);
    check("de_valid", 32'd1, 32'(de_valid));
    check("de_rs1_val", v, de_rs1_val);
  endtask

  task automatic test_mispredict();
    int n;
    @(posedge clk);
    agex_mispred <= 1'b1;
    drive_fetch(add_word(5'd7, 5'd0, 5'd0), 32'h300);
    @(negedge clk);
    check("stall", 32'd1, 32'(stall));
    @(posedge clk);
    agex_mispred <= 1'b0;
    fe_valid     <= 1'b0;  // fetch drops the wrong-path instruction
    @(negedge clk);
    check("de_valid", 32'd0, 32'(de_valid));
    check("de_wr_reg", 32'd0, 32'(de_wr_reg));
    issue(add_word(5'd0, 5'd7, 5'd0), 32'h304, n);
    check("stall cycles", 32'd0, 32'(n));
    check("de_valid", 32'd1, 32'(de_valid));
  endtask

  task automatic test_invalid();
    logic [31:0] r;
    int          n;
    r = next_rand();
    issue({r[31:7], 7'b1111111}, 32'h400, n);
    check("de_op", 32'(OP_INVALID), 32'(de_op));
    check("de_wr_reg", 32'd0, 32'(de_wr_reg));
    check("de_rd_mem", 32'd0, 32'(de_rd_mem));
    check("de_wr_mem", 32'd0, 32'(de_wr_mem));
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int n;
    fe_valid     = 1'b0;
    fe_inst      = '0;
    fe_pc        = '0;
    fe_pc_plus   = '0;
    fe_pc_next   = '0;
    wb_wr_reg    = 1'b0;
    wb_regno     = '0;
    wb_value     = '0;
    agex_mispred = 1'b0;
    n = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_run("timeout: reset was never released");
    end
    @(negedge clk);
    test_reset_idle();
    test_wb_read();
    test_decode();
    test_raw_hazard();
    test_mispredict();
    test_invalid();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);
  localparam int HALF_PERIOD  = 50;  // ns, 100 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                             clk,
  input  logic                             reset,
  // from fetch
  input  logic                             fe_valid,
  input  decode_pkg::instr_t               fe_inst,
  input  logic [decode_pkg::DATA_W-1:0]    fe_pc,
  input  logic [decode_pkg::DATA_W-1:0]    fe_pc_plus,
  input  logic [decode_pkg::DATA_W-1:0]    fe_pc_next,
  output logic                             stall,
  // from write-back
  input  logic                             wb_wr_reg,
  input  logic [decode_pkg::REGNO_W-1:0]   wb_regno,
  input  logic [decode_pkg::DATA_W-1:0]    wb_value,
  // from agex
  input  logic                             agex_mispred,
  // decode latch toward execute
  output logic                             de_valid,
  output logic [decode_pkg::DATA_W-1:0]    de_pc,
  output logic [decode_pkg::DATA_W-1:0]    de_pc_plus,
  output logic [decode_pkg::DATA_W-1:0]    de_pc_next,
  output decode_pkg::inst_op_t             de_op,
  output logic [decode_pkg::DATA_W-1:0]    de_rs1_val,
  output logic [decode_pkg::DATA_W-1:0]    de_rs2_val,
  output logic [decode_pkg::DATA_W-1:0]    de_imm,
  output logic                             de_is_br,
  output logic                             de_is_jmp,
  output logic                             de_rd_mem,
  output logic                             de_wr_mem,
  output logic                             de_wr_reg,
  output logic [decode_pkg::REGNO_W-1:0]   de_rd
);
  import decode_pkg::*;

  inst_op_t           dec_op;
  imm_kind_t          dec_imm_kind;
  logic [REGNO_W-1:0] dec_rs1, dec_rs2, dec_rd;
  logic               dec_use_rs1, dec_use_rs2;
  logic               dec_is_br, dec_is_jmp, dec_rd_mem, dec_wr_mem, dec_wr_reg;
  logic [DATA_W-1:0]  dec_imm;
  logic [DATA_W-1:0]  rs1_val, rs2_val;
  logic               hazard;
  logic               accept;  // instruction moves into the latch at this edge

  instr_decoder i_instr_decoder (
    .inst(fe_inst), .op(dec_op), .imm_kind(dec_imm_kind),
    .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
    .use_rs1(dec_use_rs1), .use_rs2(dec_use_rs2),
    .is_br(dec_is_br), .is_jmp(dec_is_jmp),
    .rd_mem(dec_rd_mem), .wr_mem(dec_wr_mem), .wr_reg(dec_wr_reg)
  );

  imm_gen i_imm_gen (.inst(fe_inst), .imm_kind(dec_imm_kind), .imm(dec_imm));

  reg_file i_reg_file (
    .clk(clk), .reset(reset), .rs1(dec_rs1), .rs2(dec_rs2),
    .wr_en(wb_wr_reg), .wr_regno(wb_regno), .wr_value(wb_value),
    .rs1_val(rs1_val), .rs2_val(rs2_val)
  );

  scoreboard i_scoreboard (
    .clk(clk), .reset(reset), .rs1(dec_rs1), .rs2(dec_rs2),
    .use_rs1(dec_use_rs1), .use_rs2(dec_use_rs2), .check(fe_valid),
    .issue(accept && dec_wr_reg), .issue_rd(dec_rd),
    .wb_wr_reg(wb_wr_reg), .wb_regno(wb_regno), .hazard(hazard)
  );

  assign stall  = hazard || agex_mispred;  // hazard is already gated by fe_valid
  assign accept = fe_valid && !stall;

  ////////////////////////////////////////////////////////////
  // decode latch
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_valid  <= 1'b0;
      de_is_br  <= 1'b0;
      de_is_jmp <= 1'b0;
      de_rd_mem <= 1'b0;
      de_wr_mem <= 1'b0;
      de_wr_reg <= 1'b0;
    end else begin
      de_valid  <= accept;
      de_is_br  <= accept && dec_is_br;
      de_is_jmp <= accept && dec_is_jmp;
      de_rd_mem <= accept && dec_rd_mem;
      de_wr_mem <= accept && dec_wr_mem;
      de_wr_reg <= accept && dec_wr_reg;
    end
  end

  // payload follows the valid bit, zeroed in a bubble
  always_ff @(posedge clk) begin
    de_pc      <= accept ? fe_pc      : '0;
    de_pc_plus <= accept ? fe_pc_plus : '0;
    de_pc_next <= accept ? fe_pc_next : '0;
    de_op      <= accept ? dec_op     : inst_op_t'('0);
    de_rs1_val <= accept ? rs1_val    : '0;
    de_rs2_val <= accept ? rs2_val    : '0;
    de_imm     <= accept ? dec_imm    : '0;
    de_rd      <= accept ? dec_rd     : '0;
  end

  a_stall_bubble: assert property (
    @(posedge clk) disable iff (reset) stall |=> !de_valid
  ) else $error("instruction passed decode during a stall");

endmodule

`default_nettype wire

// ==== source/scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [decode_pkg::REGNO_W-1:0]   rs1,
  input  logic [decode_pkg::REGNO_W-1:0]   rs2,
  input  logic                             use_rs1,
  input  logic                             use_rs2,
  input  logic                             check,     // valid instruction in decode
  input  logic                             issue,     // accepted, writes a register
  input  logic [decode_pkg::REGNO_W-1:0]   issue_rd,
  input  logic                             wb_wr_reg,
  input  logic [decode_pkg::REGNO_W-1:0]   wb_regno,
  output logic                             hazard
);
  import decode_pkg::*;

  logic [REG_COUNT-1:0] busy;  // one bit per pending write

  ////////////////////////////////////////////////////////////
  // busy bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb_wr_reg) busy[wb_regno] <= 1'b0;
      // set is applied last so a same-cycle set on that register wins
      if (issue)     busy[issue_rd] <= 1'b1;
    end
  end

  assign hazard = check && ((use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]));

  // the decoder never issues a write to x0
  a_x0_never_busy: assert property (
    @(posedge clk) disable iff (reset) !busy[0]
  ) else $error("register 0 marked busy");

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [decode_pkg::REGNO_W-1:0]   rs1,
  input  logic [decode_pkg::REGNO_W-1:0]   rs2,
  input  logic                             wr_en,
  input  logic [decode_pkg::REGNO_W-1:0]   wr_regno,
  input  logic [decode_pkg::DATA_W-1:0]    wr_value,
  output logic [decode_pkg::DATA_W-1:0]    rs1_val,
  output logic [decode_pkg::DATA_W-1:0]    rs2_val
);
  import decode_pkg::*;

  logic [DATA_W-1:0] regs [REG_COUNT];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;
    end else if (wr_en && wr_regno != '0) begin
      regs[wr_regno] <= wr_value;
    end
  end

  // x0 pinned, then write-through of the value landing at this edge
  assign rs1_val = (rs1 == '0)                   ? '0       :
                   (wr_en && wr_regno == rs1)     ? wr_value : regs[rs1];
  assign rs2_val = (rs2 == '0)                   ? '0       :
                   (wr_en && wr_regno == rs2)     ? wr_value : regs[rs2];

endmodule

`default_nettype wire

// ==== source/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  decode_pkg::instr_t              inst,
  input  decode_pkg::imm_kind_t           imm_kind,
  output logic [decode_pkg::DATA_W-1:0]   imm
);
  import decode_pkg::*;

  logic sign;  // every layout keeps its sign in the top bit

  assign sign = inst[INST_W-1];

  always_comb begin
    case (imm_kind)
      IMM_I: imm = {{20{sign}}, inst.i_view.imm};
      IMM_S: imm = {{20{sign}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
      // b: imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
      IMM_B: imm = {{19{sign}},
                    inst.s_view.imm_hi[6],
                    inst.s_view.imm_lo[0],
                    inst.s_view.imm_hi[5:0],
                    inst.s_view.imm_lo[4:1],
                    1'b0};
      IMM_U: imm = {inst.u_view.imm, 12'b0};
      // j: imm[20|10:1|11|19:12] in the upper 20 bits
      IMM_J: imm = {{11{sign}},
                    inst.u_view.imm[19],
                    inst.u_view.imm[7:0],
                    inst.u_view.imm[8],
                    inst.u_view.imm[18:9],
                    1'b0};
      default: imm = '0;  // r type and invalid words
    endcase
  end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  decode_pkg::instr_t                inst,
  output decode_pkg::inst_op_t              op,
  output decode_pkg::imm_kind_t             imm_kind,
  output logic [decode_pkg::REGNO_W-1:0]    rs1,
  output logic [decode_pkg::REGNO_W-1:0]    rs2,
  output logic [decode_pkg::REGNO_W-1:0]    rd,
  output logic                              use_rs1,
  output logic                              use_rs2,
  output logic                              is_br,
  output logic                              is_jmp,
  output logic                              rd_mem,
  output logic                              wr_mem,
  output logic                              wr_reg
);
  import decode_pkg::*;

  fmt_t fmt;
  logic writes_rd;   // op has a destination register
  logic known_op;

  // register fields sit at the same place in every layout that has them
  assign rs1 = inst.r_view.rs1;
  assign rs2 = inst.r_view.rs2;
  assign rd  = inst.r_view.rd;

  ////////////////////////////////////////////////////////////
  // opcode match
  ////////////////////////////////////////////////////////////
  always_comb begin
    op       = OP_INVALID;
    fmt      = FMT_R;
    imm_kind = IMM_NONE;
    case (inst.r_view.opcode)
      OPC_OP: begin
        case ({inst.r_view.funct7, inst.r_view.funct3})
          {F7_BASE, F3_ADD}:    op = OP_ADD;
          {F7_ALT, F3_ADD}:     op = OP_SUB;
          {F7_BASE, F3_AND}:    op = OP_AND;
          {F7_BASE, F3_OR}:     op = OP_OR;
          {F7_BASE, F3_XOR}:    op = OP_XOR;
          {F7_BASE, F3_SLT}:    op = OP_SLT;
          {F7_BASE, F3_SLTU}:   op = OP_SLTU;
          {F7_ALT, F3_SR}:      op = OP_SRA;
          {F7_BASE, F3_SR}:     op = OP_SRL;
          {F7_BASE, F3_SLL}:    op = OP_SLL;
          {F7_MULDIV, F3_MUL}:  op = OP_MUL;
          default:              op = OP_INVALID;
        endcase
      end
      OPC_OP_IMM: begin
        fmt      = FMT_I;
        imm_kind = IMM_I;
        case (inst.i_view.funct3)
          F3_ADD:  op = OP_ADDI;
          F3_AND:  op = OP_ANDI;
          F3_OR:   op = OP_ORI;
          F3_XOR:  op = OP_XORI;
          F3_SLT:  op = OP_SLTI;
          F3_SLTU: op = OP_SLTIU;
          F3_SLL:  op = (inst.r_view.funct7 == F7_BASE) ? OP_SLLI : OP_INVALID;
          default: begin  // shift right with funct7 picking the kind
            if (inst.r_view.funct7 == F7_BASE)
              op = OP_SRLI;
            else if (inst.r_view.funct7 == F7_ALT)
              op = OP_SRAI;
          end
        endcase
      end
      OPC_LUI, OPC_AUIPC: begin
        fmt      = FMT_U;
        imm_kind = IMM_U;
        op       = (inst.u_view.opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
      end
      OPC_LOAD: begin
        fmt      = FMT_I;
        imm_kind = IMM_I;
        if (inst.i_view.funct3 == F3_LW) op = OP_LW;
      end
      OPC_STORE: begin
        fmt      = FMT_S;
        imm_kind = IMM_S;
        if (inst.s_view.funct3 == F3_SW) op = OP_SW;
      end
      OPC_JAL: begin
        fmt      = FMT_U;
        imm_kind = IMM_J;
        op       = OP_JAL;
      end
      OPC_JALR: begin
        fmt      = FMT_I;
        imm_kind = IMM_I;
        if (inst.i_view.funct3 == F3_JALR) op = OP_JALR;
      end
      OPC_BRANCH: begin
        fmt      = FMT_S;
        imm_kind = IMM_B;
        case (inst.s_view.funct3)
          F3_BEQ:  op = OP_BEQ;
          F3_BNE:  op = OP_BNE;
          F3_BLT:  op = OP_BLT;
          F3_BGE:  op = OP_BGE;
          F3_BLTU: op = OP_BLTU;
          F3_BGEU: op = OP_BGEU;
          default: op = OP_INVALID;
        endcase
      end
      OPC_SYSTEM: begin
        fmt      = FMT_I;
        imm_kind = IMM_I;  // csr number
        if (inst.i_view.funct3 == F3_CSRRS)
          op = OP_CSRR;
        else if (inst.i_view.funct3 == F3_CSRRW)
          op = OP_CSRW;
      end
      default: op = OP_INVALID;
    endcase
    if (op == OP_INVALID) imm_kind = IMM_NONE;
  end

  ////////////////////////////////////////////////////////////
  // operand use and control flags
  ////////////////////////////////////////////////////////////
  assign known_op = (op != OP_INVALID);
  assign use_rs1  = known_op && (fmt != FMT_U);
  assign use_rs2  = known_op && (fmt == FMT_R || fmt == FMT_S);

  assign is_br  = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_jmp = op inside {OP_JAL, OP_JALR};
  assign rd_mem = (op == OP_LW);
  assign wr_mem = (op == OP_SW);

  assign writes_rd = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
                                OP_SRA, OP_SRL, OP_SLL, OP_MUL, OP_ADDI, OP_ANDI, OP_ORI,
                                OP_XORI, OP_SLTI, OP_SLTIU, OP_SRAI, OP_SRLI, OP_SLLI,
                                OP_LUI, OP_AUIPC, OP_LW, OP_JAL, OP_JALR, OP_CSRR};
  assign wr_reg = writes_rd && (rd != '0);  // x0 never becomes a destination

endmodule

`default_nettype wire

// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int DATA_W    = 32;  // data and pc
  localparam int REG_COUNT = 32;
  localparam int REGNO_W   = 5;
  localparam int INST_W    = 32;

  ////////////////////////////////////////////////////////////
  // opcodes and sub-codes
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // alu funct3, shared by register and immediate forms
  localparam logic [2:0] F3_ADD   = 3'b000;  // also sub
  localparam logic [2:0] F3_SLL   = 3'b001;
  localparam logic [2:0] F3_SLT   = 3'b010;
  localparam logic [2:0] F3_SLTU  = 3'b011;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_SR    = 3'b101;  // srl and sra
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  localparam logic [2:0] F3_MUL   = 3'b000;

  localparam logic [2:0] F3_LW    = 3'b010;
  localparam logic [2:0] F3_SW    = 3'b010;
  localparam logic [2:0] F3_JALR  = 3'b000;

  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_BLT   = 3'b100;
  localparam logic [2:0] F3_BGE   = 3'b101;
  localparam logic [2:0] F3_BLTU  = 3'b110;
  localparam logic [2:0] F3_BGEU  = 3'b111;

  localparam logic [2:0] F3_CSRRW = 3'b001;  // csrw alias
  localparam logic [2:0] F3_CSRRS = 3'b010;  // csrr alias

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  ////////////////////////////////////////////////////////////
  // internal encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [5:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
    OP_SRA, OP_SRL, OP_SLL, OP_MUL,
    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU,
    OP_SRAI, OP_SRLI, OP_SLLI,
    OP_LUI, OP_AUIPC, OP_LW, OP_SW, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_CSRR, OP_CSRW,
    OP_INVALID
  } inst_op_t;

  typedef enum logic [1:0] {FMT_R, FMT_I, FMT_S, FMT_U} fmt_t;

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_t;

  // instruction word layouts, b is read through s and j through u
  typedef struct packed {
    logic [6:0]         funct7;
    logic [REGNO_W-1:0] rs2;
    logic [REGNO_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [REGNO_W-1:0] rd;
    logic [6:0]         opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]        imm;
    logic [REGNO_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [REGNO_W-1:0] rd;
    logic [6:0]         opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0]         imm_hi;
    logic [REGNO_W-1:0] rs2;
    logic [REGNO_W-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         imm_lo;
    logic [6:0]         opcode;
  } s_view_t;

  typedef struct packed {
    logic [19:0]        imm;
    logic [REGNO_W-1:0] rd;
    logic [6:0]         opcode;
  } u_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    s_view_t s_view;
    u_view_t u_view;
  } instr_t;

endpackage

`default_nettype wire
